// ==== mad_config.svh ====
//--------------------------------------------------------------------------
// Build-time configuration of the multiply-add engine
// Data width, lane count and multi-cycle length
//--------------------------------------------------------------------------
`ifndef MAD_CONFIG_SVH
`define MAD_CONFIG_SVH

// Operand and result width in bits
`define MAD_WIDTH	32

// Number of lanes issued round-robin
`define MAD_LANES	2

// Cycles from operand capture to registered result
// The multiply-add path is given this many cycles to settle
`define MAD_CYCLE	3

`endif

// ==== mad_data_pkg.sv ====
//--------------------------------------------------------------------------
// Datapath types of the multiply-add engine
// Operand word and result word
//--------------------------------------------------------------------------
`include "mad_config.svh"

package mad_data_pkg;

	// One unsigned operand of a, b or c
	typedef logic [`MAD_WIDTH-1:0] operand_t;

	// One result word
	// Holds a*b+c truncated to the operand width, so it wraps modulo 2^width
	typedef logic [`MAD_WIDTH-1:0] result_t;

endpackage

// ==== mad_dispatch.sv ====
//--------------------------------------------------------------------------
// Lane dispatch of the multiply-add engine
// Round-robin issue pointer, input ready, one-hot lane start,
// result collection and busy level
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mad_config.svh"

module mad_dispatch (
	input	logic					MCLK,
	input	logic					nRST,
	// Input strobe from the operand source
	input	logic					ie,
	// Lane status
	input	logic [`MAD_LANES-1:0]	lane_free,
	input	logic [`MAD_LANES-1:0]	lane_done,
	input	mad_data_pkg::result_t	lane_result [`MAD_LANES],
	// Ready level towards the operand source
	output	logic					iready,
	// One-hot start, at most one bit set
	output	logic [`MAD_LANES-1:0]	lane_start,
	// Result strobe and data
	output	logic					oe,
	output	mad_data_pkg::result_t	odata,
	output	logic					busy
);

	import mad_lane_pkg::*;

	//----------------------------------------------------------------------
	// Declarations
	//----------------------------------------------------------------------
	// Lane that takes the next operation
	lane_idx_t		ptr;

	// Operation accepted at the coming edge
	logic			accept;

	//----------------------------------------------------------------------
	// Issue side
	//----------------------------------------------------------------------
	assign iready	= lane_free[ptr];
	assign accept	= ie && iready;

	// Steer the accept to the pointed lane only
	always_comb begin
		for (int i = 0; i < `MAD_LANES; i++)
			lane_start[i] = accept && (ptr == lane_idx_t'(i));
	end

	// Pointer moves on accepted operations only, wrapping at the last lane
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST)
			ptr	<= '0;
		else if (accept) begin
			if (ptr == lane_idx_t'(`MAD_LANES-1))
				ptr	<= '0;
			else
				ptr	<= ptr + 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Result side
	//----------------------------------------------------------------------
	// Equal latency and in-order issue leave at most one lane done per cycle
	assign oe	= |lane_done;

	// Pick the done lane, zero when none is done
	always_comb begin
		odata = '0;
		for (int i = 0; i < `MAD_LANES; i++) begin
			if (lane_done[i])
				odata = lane_result[i];
		end
	end

	// Any lane still counting
	assign busy	= ~&lane_free;

endmodule

// ==== mad_engine.f ====
+incdir+.
mad_data_pkg.sv
mad_lane_pkg.sv
mad_lane.sv
mad_dispatch.sv
mad_engine.sv
mad_engine_chk.sv
mad_engine_tb.sv

// ==== mad_engine.sv ====
//--------------------------------------------------------------------------
// Multiply-add engine top
// Dispatch and the array of multi-cycle lanes
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mad_config.svh"

module mad_engine (
	input	logic					MCLK,
	input	logic					nRST,
	// Operation input, taken when ie and iready are both high
	input	logic					ie,
	input	mad_data_pkg::operand_t	a,
	input	mad_data_pkg::operand_t	b,
	input	mad_data_pkg::operand_t	c,
	output	logic					iready,
	// Result output, a one-cycle pulse MAD_CYCLE edges after accept
	output	logic					oe,
	output	mad_data_pkg::result_t	odata,
	output	logic					busy
);

	import mad_data_pkg::*;

	// Lane control and status
	logic [`MAD_LANES-1:0]	lane_start;
	logic [`MAD_LANES-1:0]	lane_free;
	logic [`MAD_LANES-1:0]	lane_done;
	result_t				lane_result [`MAD_LANES];

	//----------------------------------------------------------------------
	// Dispatch
	//----------------------------------------------------------------------
	mad_dispatch u_dispatch (
		.MCLK			(MCLK),
		.nRST			(nRST),
		.ie				(ie),
		.lane_free		(lane_free),
		.lane_done		(lane_done),
		.lane_result	(lane_result),
		.iready			(iready),
		.lane_start		(lane_start),
		.oe				(oe),
		.odata			(odata),
		.busy			(busy)
	);

	//----------------------------------------------------------------------
	// Lane array
	//----------------------------------------------------------------------
	// All lanes see the same operands, only the started one captures them
	for (genvar g = 0; g < `MAD_LANES; g++) begin : g_lane
		mad_lane u_lane (
			.MCLK		(MCLK),
			.nRST		(nRST),
			.start		(lane_start[g]),
			.a			(a),
			.b			(b),
			.c			(c),
			.free		(lane_free[g]),
			.done		(lane_done[g]),
			.result		(lane_result[g])
		);
	end

endmodule

// ==== mad_engine_chk.sv ====
//--------------------------------------------------------------------------
// Assertion checker for the multiply-add engine, bound into the top
// Latency, result value, ignored input and state after reset
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mad_config.svh"

module mad_engine_chk (
	input	logic					MCLK,
	input	logic					nRST,
	input	logic					ie,
	input	logic					iready,
	input	mad_data_pkg::operand_t	a,
	input	mad_data_pkg::operand_t	b,
	input	mad_data_pkg::operand_t	c,
	input	logic					oe,
	input	mad_data_pkg::result_t	odata,
	input	logic					busy
);

	import mad_data_pkg::*;

	// The oe cycle follows edge k+MAD_CYCLE and is sampled one edge later
	localparam int	LAT	= `MAD_CYCLE + 1;

	logic						accept;
	logic [2*`MAD_WIDTH-1:0]	mad_full;
	result_t					mad_ref;

	// Failed assertions so far, read by the testbench
	int unsigned	fail_cnt = 0;

	assign accept	= ie && iready;

	// Product plus addend at double width, no bits lost
	assign mad_full	= {`MAD_WIDTH'(0), a} * {`MAD_WIDTH'(0), b} + {`MAD_WIDTH'(0), c};

	// Low word only, which is the value modulo 2^width
	assign mad_ref	= mad_full[`MAD_WIDTH-1:0];

	// Every accept gives an oe at the fixed latency
	a_latency: assert property (@(posedge MCLK) disable iff (!nRST)
		accept |-> ##LAT oe)
		else begin
			fail_cnt++;
			$error("oe missing at fixed latency after accept");
		end

	// Every oe carries the result of the operation accepted LAT edges before
	a_value: assert property (@(posedge MCLK) disable iff (!nRST)
		oe |-> ($past(accept, LAT) && (odata == $past(mad_ref, LAT))))
		else begin
			fail_cnt++;
			$error("oe without matching accept, or odata wrong");
		end

	// ie while not ready is not an operation
	a_ignored: assert property (@(posedge MCLK) disable iff (!nRST)
		(ie && !iready) |-> ##LAT !oe)
		else begin
			fail_cnt++;
			$error("ignored input produced an oe");
		end

	// First cycle after reset release
	a_reset: assert property (@(posedge MCLK)
		$rose(nRST) |-> (!oe && !busy && iready))
		else begin
			fail_cnt++;
			$error("outputs not idle after reset release");
		end

endmodule

bind mad_engine mad_engine_chk u_chk (
	.MCLK	(MCLK),
	.nRST	(nRST),
	.ie		(ie),
	.iready	(iready),
	.a		(a),
	.b		(b),
	.c		(c),
	.oe		(oe),
	.odata	(odata),
	.busy	(busy)
);

// ==== mad_engine_tb.sv ====
//--------------------------------------------------------------------------
// Testbench of the multiply-add engine
// Clock, reset, operation stimulus, result scoreboard, watchdog, report
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mad_config.svh"

module mad_engine_tb;

	import mad_data_pkg::*;

	// Operations offered over the whole run
	localparam int	OP_TOTAL	= 26;
	localparam int	WD_CYCLES	= OP_TOTAL * (`MAD_CYCLE + 2) + 200;

	logic		MCLK;
	logic		nRST;
	logic		ie;
	operand_t	a;
	operand_t	b;
	operand_t	c;
	logic		iready;
	logic		oe;
	result_t	odata;
	logic		busy;

	// Scoreboard and run statistics
	result_t	exp_q [$];
	string		test_name;
	int			err_cnt;
	int			err_mark;
	int			test_cnt;
	int			test_fail_cnt;

	mad_engine dut (
		.MCLK	(MCLK),
		.nRST	(nRST),
		.ie		(ie),
		.a		(a),
		.b		(b),
		.c		(c),
		.iready	(iready),
		.oe		(oe),
		.odata	(odata),
		.busy	(busy)
	);

	always #50 MCLK = ~MCLK;

	//----------------------------------------------------------------------
	// Reference and scoreboard
	//----------------------------------------------------------------------
	// Full product, then keep the low word
	function automatic result_t mad_mod(input operand_t x, input operand_t y,
			input operand_t z);
		logic [2*`MAD_WIDTH-1:0] full;
		full = {`MAD_WIDTH'(0), x} * {`MAD_WIDTH'(0), y} + {`MAD_WIDTH'(0), z};
		return full[`MAD_WIDTH-1:0];
	endfunction

	task automatic check_result();
		result_t exp;
		if (exp_q.size() == 0) begin
			$display("%s: result came out with no operation pending", test_name);
			err_cnt++;
		end
		else begin
			exp = exp_q.pop_front();
			if (odata !== exp) begin
				$display("ERR %s: expected %h actual %h", test_name, exp, odata);
				err_cnt++;
			end
		end
	endtask

	// Falling edge, strobes settled for the coming rising edge
	always @(negedge MCLK) begin
		if (!nRST)
			exp_q.delete();
		else begin
			if (ie && iready)
				exp_q.push_back(mad_mod(a, b, c));
			if (oe)
				check_result();
		end
	end

	//----------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------
	// Offer one operation, hold it until taken, count cycles with iready low
	task automatic issue_op(input operand_t oa, input operand_t ob, input operand_t oc,
			output int stalls);
		logic taken;
		stalls = 0;
		taken = 1'b0;
		ie = 1'b1;
		a = oa;
		b = ob;
		c = oc;
		while (!taken) begin
			@(negedge MCLK);
			taken = iready;
			if (!taken)
				stalls++;
			@(posedge MCLK);
			#10;
		end
	endtask

	// Wait for all lanes idle and the last done pulse
	task automatic drain();
		ie = 1'b0;
		do
			@(negedge MCLK);
		while (busy);
		repeat (2) @(negedge MCLK);
		@(posedge MCLK);
		#10;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_mark = err_cnt + int'(dut.u_chk.fail_cnt);
	endtask

	task automatic end_test();
		int errs;
		if (exp_q.size() != 0) begin
			$display("%s: %0d expected results never came out", test_name, exp_q.size());
			err_cnt++;
		end
		errs = err_cnt + int'(dut.u_chk.fail_cnt) - err_mark;
		test_cnt++;
		if (errs != 0)
			test_fail_cnt++;
		$display("test %s finished with %0d errors", test_name, errs);
	endtask

	// Wrong stall or busy count
	task automatic check_count(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s: expected %0d actual %0d (%s)", test_name, exp, act, what);
			err_cnt++;
		end
	endtask

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		int stalls;
		int stall_sum;
		int busy_cycles;
		void'($urandom(32'hefdf_1910));
		MCLK = 1'b0;
		nRST = 1'b0;
		ie = 1'b0;
		a = '0;
		b = '0;
		c = '0;
		err_cnt = 0;
		test_cnt = 0;
		test_fail_cnt = 0;
		test_name = "reset";
		repeat (10) @(posedge MCLK);
		#10;
		nRST = 1'b1;

		// One operation, 3*4+5
		begin_test("single");
		issue_op(3, 4, 5, stalls);
		check_count("stalls", 0, stalls);
		ie = 1'b0;
		busy_cycles = 0;
		@(negedge MCLK);
		while (busy) begin
			busy_cycles++;
			@(negedge MCLK);
		end
		// Lane counts as free again in its last countdown cycle
		check_count("busy cycles", `MAD_CYCLE - 1, busy_cycles);
		drain();
		end_test();

		// Nine back-to-back operations with ie held high
		begin_test("stream");
		stall_sum = 0;
		for (int i = 0; i < 9; i++) begin
			issue_op(3 + 2 * i, 4 + 2 * i, 5 + 2 * i, stalls);
			stall_sum += stalls;
		end
		check_count("stalls", (9 - 1) / `MAD_LANES * (`MAD_CYCLE - `MAD_LANES), stall_sum);
		drain();
		end_test();

		// Third operation offered while all lanes run
		begin_test("ignored");
		issue_op(100, 200, 300, stalls);
		issue_op(7, 11, 13, stalls);
		issue_op(32'h0000_dead, 32'h0000_beef, 32'h0000_1234, stalls);
		check_count("stalls", `MAD_CYCLE - `MAD_LANES, stalls);
		drain();
		end_test();

		// Products past 32 bits
		begin_test("wrap");
		issue_op('1, '1, '1, stalls);
		issue_op(32'h8000_0000, 2, 5, stalls);
		for (int i = 0; i < 8; i++)
			issue_op($urandom(), $urandom(), $urandom(), stalls);
		drain();
		end_test();

		// Reset with two operations in flight
		begin_test("reset");
		issue_op(21, 22, 23, stalls);
		issue_op(24, 25, 26, stalls);
		ie = 1'b0;
		@(posedge MCLK);
		#10;
		nRST = 1'b0;
		repeat (3) @(posedge MCLK);
		#10;
		nRST = 1'b1;
		@(negedge MCLK);
		if (oe || busy || !iready) begin
			$display("%s: outputs not idle after reset release", test_name);
			err_cnt++;
		end
		@(posedge MCLK);
		#10;
		issue_op(30, 31, 32, stalls);
		@(negedge MCLK);
		// Only lane 0 counting
		if (dut.lane_free !== {{(`MAD_LANES-1){1'b1}}, 1'b0}) begin
			$display("%s: first operation after reset did not go to lane 0", test_name);
			err_cnt++;
		end
		drain();
		end_test();

		$display("tests %0d, failed %0d, scoreboard errors %0d, assertion failures %0d",
			test_cnt, test_fail_cnt, err_cnt, dut.u_chk.fail_cnt);
		if (err_cnt == 0 && dut.u_chk.fail_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WD_CYCLES * 100);
		$display("watchdog expired after %0d cycles, tests did not finish", WD_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== mad_lane.sv ====
//--------------------------------------------------------------------------
// Multi-cycle multiply-add lane
// Operand capture, countdown over the settle time of a*b+c,
// result register and one-cycle done pulse
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "mad_config.svh"

module mad_lane (
	input	logic					MCLK,
	input	logic					nRST,
	// Start pulse from dispatch, one cycle per operation
	input	logic					start,
	input	mad_data_pkg::operand_t	a,
	input	mad_data_pkg::operand_t	b,
	input	mad_data_pkg::operand_t	c,
	// Lane can take a start at the next edge
	output	logic					free,
	// One-cycle pulse with result valid
	output	logic					done,
	output	mad_data_pkg::result_t	result
);

	import mad_data_pkg::*;
	import mad_lane_pkg::*;

	//----------------------------------------------------------------------
	// Declarations
	//----------------------------------------------------------------------
	// Captured operands, held stable for the whole countdown
	operand_t		a_q;
	operand_t		b_q;
	operand_t		c_q;

	// Remaining cycles of the running operation
	cycle_cnt_t		cnt;

	// Long combinational product-plus-addend
	result_t		mad_sum;

	// Last cycle of the countdown
	logic			expire;

	//----------------------------------------------------------------------
	// Multi-cycle path
	//----------------------------------------------------------------------
	// Only sampled when the count expires
	assign mad_sum	= a_q * b_q + c_q;

	assign expire	= (cnt == cycle_cnt_t'(1));

	// Free in the last countdown cycle as well
	// The old result is sampled at the same edge that takes new operands,
	// so a lane restarts without a gap
	assign free		= (cnt == '0) || expire;

	// Operand capture
	always_ff @(posedge MCLK) begin
		if (start) begin
			a_q	<= a;
			b_q	<= b;
			c_q	<= c;
		end
	end

	//----------------------------------------------------------------------
	// Countdown and done
	//----------------------------------------------------------------------
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			cnt		<= '0;
			done	<= 1'b0;
		end
		else begin
			// Pulse for the cycle after the expiring edge
			done	<= expire;

			if (start)
				cnt	<= cycle_cnt_t'(`MAD_CYCLE);
			else if (cnt != '0)
				cnt	<= cnt - 1'b1;
		end
	end

	// Result register, loaded once per operation
	always_ff @(posedge MCLK) begin
		if (expire)
			result	<= mad_sum;
	end

endmodule

// ==== mad_lane_pkg.sv ====
//--------------------------------------------------------------------------
// Lane control types of the multiply-add engine
// Lane index for the issue pointer and lane countdown
//--------------------------------------------------------------------------
`include "mad_config.svh"

package mad_lane_pkg;

	// Index of one lane
	// One bit for two lanes, at least one bit always
	typedef logic [(`MAD_LANES > 1 ? $clog2(`MAD_LANES) : 1)-1:0] lane_idx_t;

	// Countdown of one lane
	// Must hold the value MAD_CYCLE itself, zero means idle
	typedef logic [$clog2(`MAD_CYCLE+1)-1:0] cycle_cnt_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the multiply-add engine testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f mad_engine.f \
	--top-module mad_engine_tb \
	-o mad_engine_sim

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/mad_engine_sim +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
